/* source/fp_agg_cfg.svh */
// Build-time constants for the two-port aggregation datapath.
// Include this wherever widths, depths or header constants are needed.
`ifndef FP_AGG_CFG_SVH
`define FP_AGG_CFG_SVH

// stream beat width
`define AGG_DATA_W 64

// one summed lane and lanes per beat
`define AGG_LANE_W 32
`define AGG_NUM_LANES 2

// header beats at the start of every packet
`define AGG_HDR_BEATS 5

// destination MAC sits in bits 47:0 of header beat 0
`define AGG_MAC_W 48
`define AGG_NEW_DEST_MAC 48'hffff_ffff_ffff

// log2 of every stream FIFO depth
`define AGG_FIFO_DEPTH_BITS 4

`endif

/* source/fp_agg_pkg.sv */
// Shared types for the aggregation datapath.
// Referenced by scoped name (fp_agg_pkg::...) from the RTL and the testbench.

`include "fp_agg_cfg.svh"

package fp_agg_pkg;

  // core FSM, header beats first then summed payload
  typedef enum logic [0:0] {
    AGG_HEADER  = 1'b0,
    AGG_PAYLOAD = 1'b1
  } agg_state_e;

  // one stream beat
  typedef logic [`AGG_DATA_W-1:0] agg_data_t;

  // one 32-bit lane of a payload beat
  typedef logic [`AGG_LANE_W-1:0] agg_lane_t;

  // counts header beats, must reach AGG_HDR_BEATS - 1
  typedef logic [2:0] agg_beat_cnt_t;

endpackage

/* source/agg_stream_fifo.sv */
// Synchronous stream FIFO with valid/ready on both sides.
// Used as input buffer per port and as the result buffer; data and last travel packed.

`timescale 1ns/10ps

module agg_stream_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_BITS = 2
) (
  input  logic             axis_aclk,
  input  logic             axis_resetn,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             wr_valid,
  output logic             wr_ready,
  output logic [WIDTH-1:0] rd_data,
  output logic             rd_valid,
  input  logic             rd_ready
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count; // one extra bit to tell full from empty
  logic                  do_wr;
  logic                  do_rd;

  assign wr_ready = (count != DEPTH[DEPTH_BITS:0]);
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr]; // head of queue, no output register

  assign do_wr = wr_valid & wr_ready;
  assign do_rd = rd_valid & rd_ready;

  // storage, no reset needed
  always_ff @(posedge axis_aclk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* source/agg_core.sv */
// Aggregation core: pairs one beat from each input port per cycle.
// Header beats pass port 0 through with the destination MAC rewritten,
// payload beats carry the lane-wise wrapping sum of both ports.

`timescale 1ns/10ps

`include "fp_agg_cfg.svh"

module agg_core (
  input  logic                  axis_aclk,
  input  logic                  axis_resetn,

  input  fp_agg_pkg::agg_data_t in0_tdata,
  input  logic                  in0_tvalid,
  output logic                  in0_tready,
  input  logic                  in0_tlast,

  input  fp_agg_pkg::agg_data_t in1_tdata,
  input  logic                  in1_tvalid,
  output logic                  in1_tready,
  input  logic                  in1_tlast,

  output fp_agg_pkg::agg_data_t res_tdata,
  output logic                  res_tvalid,
  input  logic                  res_tready,
  output logic                  res_tlast
);

  localparam int LW = `AGG_LANE_W;
  localparam fp_agg_pkg::agg_beat_cnt_t LAST_HDR = `AGG_HDR_BEATS - 1;

  fp_agg_pkg::agg_state_e    state;
  fp_agg_pkg::agg_beat_cnt_t hdr_cnt;

  fp_agg_pkg::agg_lane_t lane0    [`AGG_NUM_LANES];
  fp_agg_pkg::agg_lane_t lane1    [`AGG_NUM_LANES];
  fp_agg_pkg::agg_lane_t lane_sum [`AGG_NUM_LANES];
  fp_agg_pkg::agg_data_t sum_data;
  fp_agg_pkg::agg_data_t hdr_data;

  logic pop;

  // a result exists only when both ports have a beat
  assign res_tvalid = in0_tvalid & in1_tvalid;
  assign pop        = res_tvalid & res_tready;

  // both ports always advance together
  assign in0_tready = pop;
  assign in1_tready = pop;

  assign res_tlast = in0_tlast; // ports are expected to end together

  // lane 0 lives in the low half of the beat
  for (genvar g = 0; g < `AGG_NUM_LANES; g++) begin : g_lane
    assign lane0[g]    = in0_tdata[g*LW +: LW];
    assign lane1[g]    = in1_tdata[g*LW +: LW];
    assign lane_sum[g] = lane0[g] + lane1[g]; // wraps mod 2^32
    assign sum_data[g*LW +: LW] = lane_sum[g];
  end

  // header path, port 1 header is dropped
  always_comb begin
    hdr_data = in0_tdata;
    if (hdr_cnt == '0) begin
      hdr_data[`AGG_MAC_W-1:0] = `AGG_NEW_DEST_MAC; // beat 0 carries dest MAC
    end
  end

  assign res_tdata = (state == fp_agg_pkg::AGG_HEADER) ? hdr_data : sum_data;

  // state and header counter only move on a pop
  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      state   <= fp_agg_pkg::AGG_HEADER;
      hdr_cnt <= '0;
    end else if (pop) begin
      case (state)
        fp_agg_pkg::AGG_HEADER: begin
          if (hdr_cnt == LAST_HDR) begin
            state   <= fp_agg_pkg::AGG_PAYLOAD;
            hdr_cnt <= '0;
          end else begin
            hdr_cnt <= hdr_cnt + 1'b1;
          end
        end
        fp_agg_pkg::AGG_PAYLOAD: begin
          // end of packet, next beat starts a new header
          if (in0_tlast) begin
            state   <= fp_agg_pkg::AGG_HEADER;
            hdr_cnt <= '0;
          end
        end
        default: begin
          state   <= fp_agg_pkg::AGG_HEADER;
          hdr_cnt <= '0;
        end
      endcase
    end
  end

endmodule

/* source/fp_agg_top.sv */
// Top level of the two-port aggregation datapath.
// Each input port is buffered, the core merges the pair, and the result
// leaves through a buffered output stream.

`timescale 1ns/10ps

`include "fp_agg_cfg.svh"

module fp_agg_top (
  input  logic                  axis_aclk,
  input  logic                  axis_resetn,

  input  fp_agg_pkg::agg_data_t s0_tdata,
  input  logic                  s0_tvalid,
  output logic                  s0_tready,
  input  logic                  s0_tlast,

  input  fp_agg_pkg::agg_data_t s1_tdata,
  input  logic                  s1_tvalid,
  output logic                  s1_tready,
  input  logic                  s1_tlast,

  output fp_agg_pkg::agg_data_t m_tdata,
  output logic                  m_tvalid,
  input  logic                  m_tready,
  output logic                  m_tlast
);

  localparam int FIFO_W = `AGG_DATA_W + 1; // beat plus last flag

  fp_agg_pkg::agg_data_t in0_tdata;
  logic                  in0_tvalid;
  logic                  in0_tready;
  logic                  in0_tlast;

  fp_agg_pkg::agg_data_t in1_tdata;
  logic                  in1_tvalid;
  logic                  in1_tready;
  logic                  in1_tlast;

  fp_agg_pkg::agg_data_t res_tdata;
  logic                  res_tvalid;
  logic                  res_tready;
  logic                  res_tlast;

  agg_stream_fifo #(.WIDTH(FIFO_W), .DEPTH_BITS(`AGG_FIFO_DEPTH_BITS)) in0_fifo (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .wr_data     ({s0_tlast, s0_tdata}),
    .wr_valid    (s0_tvalid),
    .wr_ready    (s0_tready),
    .rd_data     ({in0_tlast, in0_tdata}),
    .rd_valid    (in0_tvalid),
    .rd_ready    (in0_tready)
  );

  agg_stream_fifo #(.WIDTH(FIFO_W), .DEPTH_BITS(`AGG_FIFO_DEPTH_BITS)) in1_fifo (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .wr_data     ({s1_tlast, s1_tdata}),
    .wr_valid    (s1_tvalid),
    .wr_ready    (s1_tready),
    .rd_data     ({in1_tlast, in1_tdata}),
    .rd_valid    (in1_tvalid),
    .rd_ready    (in1_tready)
  );

  agg_core core (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .in0_tdata   (in0_tdata),
    .in0_tvalid  (in0_tvalid),
    .in0_tready  (in0_tready),
    .in0_tlast   (in0_tlast),
    .in1_tdata   (in1_tdata),
    .in1_tvalid  (in1_tvalid),
    .in1_tready  (in1_tready),
    .in1_tlast   (in1_tlast),
    .res_tdata   (res_tdata),
    .res_tvalid  (res_tvalid),
    .res_tready  (res_tready),
    .res_tlast   (res_tlast)
  );

  // result buffer, back-pressure from m_tready stalls the core through res_tready
  agg_stream_fifo #(.WIDTH(FIFO_W), .DEPTH_BITS(`AGG_FIFO_DEPTH_BITS)) out_fifo (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .wr_data     ({res_tlast, res_tdata}),
    .wr_valid    (res_tvalid),
    .wr_ready    (res_tready),
    .rd_data     ({m_tlast, m_tdata}),
    .rd_valid    (m_tvalid),
    .rd_ready    (m_tready)
  );

endmodule

/* tests/fp_agg_asserts.sv */
// Concurrent checks on the aggregation core, attached with bind.
// Port pairing, result stability under back-pressure and header framing.

`timescale 1ns/10ps

module fp_agg_asserts (
  input logic                   axis_aclk,
  input logic                   axis_resetn,
  input logic                   in0_tlast,
  input logic                   in1_tlast,
  input logic                   res_tvalid,
  input logic                   res_tready,
  input fp_agg_pkg::agg_data_t  res_tdata,
  input fp_agg_pkg::agg_state_e state
);

  logic pop;

  assign pop = res_tvalid & res_tready; // both inputs pop with the push

  // both ports must end their packets on the same beat
  equal_length: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    pop |-> (in0_tlast == in1_tlast))
    else $error("ports 0 and 1 ended packets on different beats");

  result_stable: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    (res_tvalid && !res_tready) |=> (res_tvalid && $stable(res_tdata)))
    else $error("result beat changed while stalled");

  // a packet cannot end inside its header
  no_last_in_header: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    (pop && state == fp_agg_pkg::AGG_HEADER) |-> !in0_tlast)
    else $error("tlast seen on a header beat");

endmodule

bind agg_core fp_agg_asserts core_asserts (
  .axis_aclk   (axis_aclk),
  .axis_resetn (axis_resetn),
  .in0_tlast   (in0_tlast),
  .in1_tlast   (in1_tlast),
  .res_tvalid  (res_tvalid),
  .res_tready  (res_tready),
  .res_tdata   (res_tdata),
  .state       (state)
);

/* tests/fp_agg_tb.sv */
// Self-checking testbench for the two-port aggregation top level.
// LFSR-driven packet pairs feed both ports with random gaps and output stalls;
// every result beat is compared with a queue built from the aggregation rules.

`timescale 1ns/10ps

`include "fp_agg_cfg.svh"

module fp_agg_tb;

  localparam int NUM_PKTS       = 40;
  localparam int MAX_PAYLOAD    = 8;
  localparam int LW             = `AGG_LANE_W;
  localparam int TIMEOUT_CYCLES = NUM_PKTS * (`AGG_HDR_BEATS + MAX_PAYLOAD) * 8 + 200;
  localparam logic [31:0] LFSR_SEED = 32'hd5ed149b;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

  logic                  axis_aclk;
  logic                  axis_resetn;
  fp_agg_pkg::agg_data_t s0_tdata;
  logic                  s0_tvalid;
  logic                  s0_tready;
  logic                  s0_tlast;
  fp_agg_pkg::agg_data_t s1_tdata;
  logic                  s1_tvalid;
  logic                  s1_tready;
  logic                  s1_tlast;
  fp_agg_pkg::agg_data_t m_tdata;
  logic                  m_tvalid;
  logic                  m_tready;
  logic                  m_tlast;

  // stimulus per port and expected result stream
  fp_agg_pkg::agg_data_t s0_data_q [$];
  logic                  s0_last_q [$];
  fp_agg_pkg::agg_data_t s1_data_q [$];
  logic                  s1_last_q [$];
  fp_agg_pkg::agg_data_t exp_data_q [$];
  logic                  exp_last_q [$];
  logic                  exp_hdr_q  [$]; // 1 for header beats

  logic [31:0] lfsr_state;
  logic        fire0;
  logic        fire1;
  int          idx0;
  int          idx1;
  int          rx_cnt;
  int          total_beats;
  int          cycles;

  fp_agg_top DUT (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .s0_tdata    (s0_tdata),
    .s0_tvalid   (s0_tvalid),
    .s0_tready   (s0_tready),
    .s0_tlast    (s0_tlast),
    .s1_tdata    (s1_tdata),
    .s1_tvalid   (s1_tvalid),
    .s1_tready   (s1_tready),
    .s1_tlast    (s1_tlast),
    .m_tdata     (m_tdata),
    .m_tvalid    (m_tvalid),
    .m_tready    (m_tready),
    .m_tlast     (m_tlast)
  );

  initial begin
    axis_aclk = 1'b0;
    forever #10 axis_aclk = ~axis_aclk;
  end

  // one Galois step, output bit is the old lsb
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r          = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_header(input fp_agg_pkg::agg_data_t got,
                              input fp_agg_pkg::agg_data_t exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: header beat %0d got %h expected %h",
               $time, rx_cnt, got, exp);
      fail_run();
    end
  endtask

  task automatic check_lane(input fp_agg_pkg::agg_lane_t got,
                            input fp_agg_pkg::agg_lane_t exp, input int lane);
    if (got !== exp) begin
      $display("** Error at %0d ns: beat %0d lane %0d sum got %h expected %h",
               $time, rx_cnt, lane, got, exp);
      fail_run();
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: beat %0d m_tlast got %b expected %b",
               $time, rx_cnt, got, exp);
      fail_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s got %b expected %b", $time, what, got, exp);
      fail_run();
    end
  endtask

  // reference model: fills both port queues and the expected result queue
  task automatic build_packets();
    int                    n_pay;
    fp_agg_pkg::agg_data_t w0;
    fp_agg_pkg::agg_data_t w1;
    fp_agg_pkg::agg_data_t w_exp;
    fp_agg_pkg::agg_lane_t a0;
    fp_agg_pkg::agg_lane_t a1;
    for (int p = 0; p < NUM_PKTS; p++) begin
      n_pay = 1 + int'(rand_bits(3)); // 1 to 8 payload beats
      for (int h = 0; h < `AGG_HDR_BEATS; h++) begin
        w0[63:32] = rand_bits(32);
        w0[31:0]  = rand_bits(32);
        w1[63:32] = rand_bits(32);
        w1[31:0]  = rand_bits(32);
        w_exp     = w0; // port 1 header is dropped
        if (h == 0) begin
          w_exp[`AGG_MAC_W-1:0] = `AGG_NEW_DEST_MAC;
        end
        s0_data_q.push_back(w0);
        s0_last_q.push_back(1'b0);
        s1_data_q.push_back(w1);
        s1_last_q.push_back(1'b0);
        exp_data_q.push_back(w_exp);
        exp_last_q.push_back(1'b0);
        exp_hdr_q.push_back(1'b1);
      end
      for (int b = 0; b < n_pay; b++) begin
        for (int l = 0; l < `AGG_NUM_LANES; l++) begin
          a0 = rand_bits(LW);
          a1 = rand_bits(LW);
          w0[l*LW +: LW]    = a0;
          w1[l*LW +: LW]    = a1;
          w_exp[l*LW +: LW] = a0 + a1; // wraps at 32 bits
        end
        s0_data_q.push_back(w0);
        s0_last_q.push_back(b == n_pay - 1);
        s1_data_q.push_back(w1);
        s1_last_q.push_back(b == n_pay - 1);
        exp_data_q.push_back(w_exp);
        exp_last_q.push_back(b == n_pay - 1);
        exp_hdr_q.push_back(1'b0);
      end
    end
  endtask

  // called 2 ns after the edge; beats held while valid and not accepted
  task automatic drive_inputs();
    if (fire0) idx0++;
    if (fire1) idx1++;
    if (!s0_tvalid || fire0) begin
      s0_tvalid = (idx0 < s0_data_q.size()) && (rand_bits(2) != 32'd0);
      if (s0_tvalid) begin
        s0_tdata = s0_data_q[idx0];
        s0_tlast = s0_last_q[idx0];
      end
    end
    if (!s1_tvalid || fire1) begin
      s1_tvalid = (idx1 < s1_data_q.size()) && (rand_bits(2) != 32'd0);
      if (s1_tvalid) begin
        s1_tdata = s1_data_q[idx1];
        s1_tlast = s1_last_q[idx1];
      end
    end
    m_tready = (rand_bits(2) != 32'd0); // low about a quarter of the time
  endtask

  task automatic check_output();
    fp_agg_pkg::agg_data_t exp_d;
    logic                  exp_l;
    logic                  exp_h;
    if (exp_data_q.size() == 0) begin
      $display("result beat at %0d ns arrived with nothing left to expect", $time);
      fail_run();
    end
    exp_d = exp_data_q.pop_front();
    exp_l = exp_last_q.pop_front();
    exp_h = exp_hdr_q.pop_front();
    if (exp_h) begin
      check_header(m_tdata, exp_d);
    end else begin
      for (int l = 0; l < `AGG_NUM_LANES; l++) begin
        check_lane(m_tdata[l*LW +: LW], exp_d[l*LW +: LW], l);
      end
    end
    check_last(m_tlast, exp_l);
    rx_cnt++;
  endtask

  initial begin
    lfsr_state  = LFSR_SEED;
    axis_resetn = 1'b0;
    s0_tdata    = '0;
    s0_tvalid   = 1'b0;
    s0_tlast    = 1'b0;
    s1_tdata    = '0;
    s1_tvalid   = 1'b0;
    s1_tlast    = 1'b0;
    m_tready    = 1'b0;
    fire0       = 1'b0;
    fire1       = 1'b0;
    idx0        = 0;
    idx1        = 0;
    rx_cnt      = 0;
    cycles      = 0;
    build_packets();
    total_beats = exp_data_q.size();

    repeat (2) @(posedge axis_aclk);
    #2;
    axis_resetn = 1'b1;

    // idle outputs before any input
    @(negedge axis_aclk);
    check_flag(m_tvalid, 1'b0, "m_tvalid after reset");
    check_flag(s0_tready, 1'b1, "s0_tready after reset");
    check_flag(s1_tready, 1'b1, "s1_tready after reset");

    while (rx_cnt < total_beats) begin
      @(posedge axis_aclk);
      #2;
      drive_inputs();
      @(negedge axis_aclk); // handshakes stable here until the next edge
      fire0 = s0_tvalid && s0_tready;
      fire1 = s1_tvalid && s1_tready;
      if (m_tvalid && m_tready) begin
        check_output();
      end
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("timeout: only %0d of %0d result beats after %0d cycles",
                 rx_cnt, total_beats, cycles);
        fail_run();
      end
    end

    // no stray beats once every packet is out
    @(posedge axis_aclk);
    #2;
    s0_tvalid = 1'b0;
    s1_tvalid = 1'b0;
    m_tready  = 1'b1;
    repeat (20) begin
      @(negedge axis_aclk);
      check_flag(m_tvalid, 1'b0, "m_tvalid after the last result");
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* fp_agg.f */
+incdir+source
source/fp_agg_pkg.sv
source/agg_stream_fifo.sv
source/agg_core.sv
source/fp_agg_top.sv
tests/fp_agg_asserts.sv
tests/fp_agg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the aggregation testbench with Verilator, run it and check the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module fp_agg_tb \
  -f fp_agg.f --Mdir obj_dir -o fp_agg_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/fp_agg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0
